// ==== Makefile ====
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= tbCacheTop
FILE_LIST ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation completed successfully
SOURCES  := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILE_LIST OBJ_DIR VFLAGS"

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+src
src/cacheTypesPkg.sv
src/memBusPkg.sv
src/dataArray.sv
src/metaDataArray.sv
src/cacheLookup.sv
src/refillController.sv
src/cacheTop.sv
testbench/mainMemoryModel.sv
testbench/tbCacheTop.sv

// ==== src/cacheLookup.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "cache_params.svh"

module cacheLookup (
  input  wire                       clk,
  input  wire                       rstN,
  input  wire                       rd,          // cpu read, held until stall low
  input  wire                       wr,          // cpu write, held until stall low
  input  wire  cacheTypesPkg::cacheAddrT addrCpu,
  input  wire  [`CACHE_DATA_W-1:0]  dataInCpu,
  input  wire  cacheTypesPkg::cacheAddrT fillAddr,  // word being refilled
  input  wire  [`CACHE_DATA_W-1:0]  fillData,
  input  wire                       fillDataWe,  // one pulse per refilled word
  input  wire                       fillMetaWe,  // install pulse after last word
  input  wire                       busy,        // controller not idle
  output logic [`CACHE_DATA_W-1:0]  dataOutCpu,
  output logic                      miss,
  output logic                      stall,
  output logic                      wrThrough    // cpu write completes this edge
);

  logic [`CACHE_TAG_W-1:0] cpuTag;
  logic [`CACHE_SET_W-1:0] cpuSet;
  cacheTypesPkg::metaT metaL, metaR;          // metadata read from each way
  cacheTypesPkg::metaT hitMetaL, hitMetaR;    // metadata after a hit
  cacheTypesPkg::metaT fillMetaL, fillMetaR;  // metadata after an install
  cacheTypesPkg::metaT wMetaL, wMetaR;
  cacheTypesPkg::metaT wbMetaL, wbMetaR;      // writeback stage payload
  logic [`CACHE_SET_W-1:0] wbSet;             // set of the pending writeback
  logic wbWeL, wbWeR;                         // writeback pending per way
  logic [`CACHE_SET_W-1:0] metaSetL, metaSetR;
  logic [`CACHE_SET_W-1:0] dataSet;
  logic [`CACHE_OFS_W-1:0] dataWord;
  logic [`CACHE_DATA_W-1:0] dataWData, dataL, dataR;
  logic dataWeL, dataWeR;
  logic hitL, hitR, goLeft, accept;

  assign cpuTag = addrCpu.fields.tag;
  assign cpuSet = addrCpu.fields.set;

  //////////////////////////////////////////////////
  // lookup stage
  //////////////////////////////////////////////////

  // pending writeback owns the row, refill owns it while busy
  assign metaSetL = wbWeL ? wbSet : (busy ? fillAddr.fields.set : cpuSet);
  assign metaSetR = wbWeR ? wbSet : (busy ? fillAddr.fields.set : cpuSet);

  assign hitL = !wbWeL && metaL.vld && (metaL.tag == cpuTag);  // masked while its row is rewritten
  assign hitR = !wbWeR && metaR.vld && (metaR.tag == cpuTag);

  assign miss   = (rd || wr) && !(hitL || hitR) && !(wbWeL || wbWeR);  // no false miss in wb cycle
  assign stall  = wbWeL || wbWeR || miss || busy;
  assign accept = (rd || wr) && (hitL || hitR) && !stall;  // access completes at this edge

  assign wrThrough  = wr && accept;      // every store also goes to memory
  assign dataOutCpu = hitR ? dataR : dataL;
  assign goLeft     = !metaL.lru;        // victim is the way not used last

  // hit way becomes mru, the other one loses lru
  always_comb begin
    hitMetaL     = metaL;
    hitMetaR     = metaR;
    hitMetaL.lru = hitL;
    hitMetaR.lru = hitR;
  end

  // install tag into the victim, age the other way
  always_comb begin
    fillMetaL     = metaL;
    fillMetaR     = metaR;
    fillMetaL.lru = goLeft;
    fillMetaR.lru = !goLeft;
    if (goLeft) begin
      fillMetaL.vld = 1'b1;
      fillMetaL.tag = fillAddr.fields.tag;
    end else begin
      fillMetaR.vld = 1'b1;
      fillMetaR.tag = fillAddr.fields.tag;
    end
  end

  //////////////////////////////////////////////////
  // metadata writeback stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbWeL <= 1'b0;
      wbWeR <= 1'b0;
    end else begin
      wbWeL <= accept && (hitMetaL != metaL);  // only rows that really change
      wbWeR <= accept && (hitMetaR != metaR);
    end
  end

  always_ff @(posedge clk) begin
    wbMetaL <= hitMetaL;
    wbMetaR <= hitMetaR;
    wbSet   <= cpuSet;
  end

  assign wMetaL = fillMetaWe ? fillMetaL : wbMetaL;
  assign wMetaR = fillMetaWe ? fillMetaR : wbMetaR;

  // data side, refill words or cpu store hit
  assign dataSet   = busy ? fillAddr.fields.set : cpuSet;
  assign dataWord  = busy ? fillAddr.fields.offset : addrCpu.fields.offset;
  assign dataWData = busy ? fillData : dataInCpu;
  assign dataWeL   = (fillDataWe && goLeft) || (wrThrough && hitL);
  assign dataWeR   = (fillDataWe && !goLeft) || (wrThrough && hitR);

  dataArray u_dataL (
    .clk(clk), .rstN(rstN), .set(dataSet), .word(dataWord),
    .we(dataWeL), .wData(dataWData), .rData(dataL)
  );

  dataArray u_dataR (
    .clk(clk), .rstN(rstN), .set(dataSet), .word(dataWord),
    .we(dataWeR), .wData(dataWData), .rData(dataR)
  );

  metaDataArray u_metaL (
    .clk(clk), .rstN(rstN), .set(metaSetL),
    .we(wbWeL || fillMetaWe), .wMeta(wMetaL), .rMeta(metaL)
  );

  metaDataArray u_metaR (
    .clk(clk), .rstN(rstN), .set(metaSetR),
    .we(wbWeR || fillMetaWe), .wMeta(wMetaR), .rMeta(metaR)
  );

endmodule

`default_nettype wire

// ==== src/cacheTop.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "cache_params.svh"

module cacheTop (
  input  wire                       clk,
  input  wire                       rstN,
  input  wire                       rd,
  input  wire                       wr,
  input  wire  [15:0]               addrCpu,
  input  wire  [`CACHE_DATA_W-1:0]  dataInCpu,
  input  wire                       memAck,
  input  wire  [`CACHE_DATA_W-1:0]  memRData,
  output logic [`CACHE_DATA_W-1:0]  dataOutCpu,
  output logic                      stall,
  output logic                      memReq,
  output memBusPkg::memOpT          memOp,
  output logic [15:0]               memAddr,
  output logic [`CACHE_DATA_W-1:0]  memWData
);

  //////////////////////////////////////////////////
  // lookup stage to refill controller
  //////////////////////////////////////////////////

  cacheTypesPkg::cacheAddrT cpuAddr;   // cpu address, decoded view
  cacheTypesPkg::cacheAddrT fillAddr;  // current refill word
  logic [`CACHE_DATA_W-1:0] fillData;
  logic miss, wrThrough, fillDataWe, fillMetaWe, busy;

  assign cpuAddr.raw = addrCpu;

  cacheLookup u_lookup (
    .clk(clk), .rstN(rstN), .rd(rd), .wr(wr),
    .addrCpu(cpuAddr), .dataInCpu(dataInCpu),
    .fillAddr(fillAddr), .fillData(fillData),
    .fillDataWe(fillDataWe), .fillMetaWe(fillMetaWe), .busy(busy),
    .dataOutCpu(dataOutCpu), .miss(miss), .stall(stall), .wrThrough(wrThrough)
  );

  refillController u_refill (
    .clk(clk), .rstN(rstN), .miss(miss), .wrThrough(wrThrough),
    .addrCpu(cpuAddr), .dataInCpu(dataInCpu),
    .memAck(memAck), .memRData(memRData),
    .fillAddr(fillAddr), .fillData(fillData),
    .fillDataWe(fillDataWe), .fillMetaWe(fillMetaWe), .busy(busy),
    .memReq(memReq), .memOp(memOp), .memAddr(memAddr), .memWData(memWData)
  );

endmodule

`default_nettype wire

// ==== src/cacheTypesPkg.sv ====
`default_nettype none

`include "cache_params.svh"

package cacheTypesPkg;

  // cpu address split into its cache fields
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;     // compared against stored tag
    logic [`CACHE_SET_W-1:0] set;     // selects the row in every way
    logic [`CACHE_OFS_W-1:0] offset;  // word inside the block
    logic byteSel;                    // ignored, word access only
  } addrFieldsT;

  // same word seen raw or as fields
  typedef union packed {
    logic [`CACHE_TAG_W+`CACHE_SET_W+`CACHE_OFS_W:0] raw;  // full 16 bit address
    addrFieldsT fields;                                   // decoded view
  } cacheAddrT;

  // per way, per set metadata, lru on top
  typedef struct packed {
    logic lru;                    // 1 = most recently used way of the set
    logic vld;                    // block holds real data
    logic [`CACHE_TAG_W-1:0] tag; // tag of the cached block
  } metaT;

endpackage

`default_nettype wire

// ==== src/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

//////////////////////////////////////////////////
// address split, msb to lsb
//   [15:10] tag  [9:4] set  [3:1] word  [0] byte
//////////////////////////////////////////////////

`define CACHE_TAG_W 6      // tag bits kept in metadata
`define CACHE_SET_W 6      // set index bits
`define CACHE_OFS_W 3      // word offset inside a block

// storage geometry
`define CACHE_DATA_W 16    // one cpu word
`define CACHE_SETS 64      // sets per way
`define CACHE_WORDS 8      // words per block

// the byte select bit below the offset is not stored anywhere,
// writes always cover a whole word

`endif

// ==== src/dataArray.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "cache_params.svh"

module dataArray (
  input  wire                      clk,
  input  wire                      rstN,
  input  wire  [`CACHE_SET_W-1:0]  set,    // row select
  input  wire  [`CACHE_OFS_W-1:0]  word,   // word inside the block
  input  wire                      we,     // write this word at the edge
  input  wire  [`CACHE_DATA_W-1:0] wData,
  output logic [`CACHE_DATA_W-1:0] rData
);

  //////////////////////////////////////////////////
  // block storage of one way
  //////////////////////////////////////////////////

  logic [`CACHE_DATA_W-1:0] mem [`CACHE_SETS][`CACHE_WORDS];  // 64 blocks of 8 words

  // read is combinational so a hit returns data in the request cycle
  assign rData = mem[set][word];

  // indexed write, no one-hot decode needed
  always_ff @(posedge clk) begin
    if (we && rstN) begin  // hold contents while in reset
      mem[set][word] <= wData;
    end
  end

endmodule

`default_nettype wire

// ==== src/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

  // operation carried with memReq on the four phase memory bus
  typedef enum logic {
    MEM_READ  = 1'b0,  // block refill word
    MEM_WRITE = 1'b1   // write through of a cpu store
  } memOpT;

  // memReq rises with op, addr and wdata stable
  // memAck rises with rdata valid, memReq drops, memAck drops
  // a new memReq waits for memAck low

endpackage

`default_nettype wire

// ==== src/metaDataArray.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "cache_params.svh"

module metaDataArray (
  input  wire                     clk,
  input  wire                     rstN,
  input  wire  [`CACHE_SET_W-1:0] set,    // shared by read and write
  input  wire                     we,
  input  wire  cacheTypesPkg::metaT wMeta,
  output cacheTypesPkg::metaT     rMeta
);

  //////////////////////////////////////////////////
  // metadata of one way, one entry per set
  //////////////////////////////////////////////////

  cacheTypesPkg::metaT mem [`CACHE_SETS];

  assign rMeta = mem[set];  // async read, feeds the tag compare

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CACHE_SETS; i++) begin
        mem[i].vld <= 1'b0;  // nothing can hit after reset
        mem[i].lru <= 1'b0;  // left way is the first victim
      end
    end else if (we) begin
      mem[set] <= wMeta;
    end
  end

endmodule

`default_nettype wire

// ==== src/refillController.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "cache_params.svh"

module refillController (
  input  wire                        clk,
  input  wire                        rstN,
  input  wire                        miss,
  input  wire                        wrThrough,
  input  wire  cacheTypesPkg::cacheAddrT addrCpu,
  input  wire  [`CACHE_DATA_W-1:0]   dataInCpu,
  input  wire                        memAck,
  input  wire  [`CACHE_DATA_W-1:0]   memRData,
  output cacheTypesPkg::cacheAddrT   fillAddr,
  output logic [`CACHE_DATA_W-1:0]   fillData,
  output logic                       fillDataWe,
  output logic                       fillMetaWe,
  output logic                       busy,
  output logic                       memReq,
  output memBusPkg::memOpT           memOp,
  output logic [15:0]                memAddr,
  output logic [`CACHE_DATA_W-1:0]   memWData
);

  typedef enum logic [2:0] {
    sIdle,        // waiting for a miss or a store
    sRequest,     // read request up, waiting for ack
    sWaitAckLow,  // req dropped, waiting for ack to fall
    sInstall,     // all 8 words in, write the tag
    sWrite        // write request up, waiting for ack
  } stateT;

  stateT state;
  memBusPkg::memOpT opReg;              // operation of the running handshake
  cacheTypesPkg::cacheAddrT addrReg;    // block address, offset walks 0..7
  logic [`CACHE_DATA_W-1:0] wDataReg;   // store data for the write through
  logic lastWord;

  assign lastWord   = (addrReg.fields.offset == {`CACHE_OFS_W{1'b1}});
  assign memReq     = (state == sRequest) || (state == sWrite);
  assign memOp      = opReg;
  assign memAddr    = addrReg.raw;     // held steady for the whole handshake
  assign memWData   = wDataReg;
  assign fillAddr   = addrReg;
  assign busy       = (state != sIdle);
  assign fillMetaWe = (state == sInstall);

  //////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state      <= sIdle;
      opReg      <= memBusPkg::MEM_READ;
      fillDataWe <= 1'b0;
    end else begin
      fillDataWe <= 1'b0;  // single cycle pulse
      case (state)
        sIdle: begin
          if (wrThrough) begin           // never together with miss
            state <= sWrite;
            opReg <= memBusPkg::MEM_WRITE;
          end else if (miss) begin
            state <= sRequest;
            opReg <= memBusPkg::MEM_READ;
          end
        end
        sRequest: begin
          if (memAck) begin
            state      <= sWaitAckLow;
            fillDataWe <= 1'b1;          // word goes into the victim way next cycle
          end
        end
        sWrite: begin
          if (memAck) begin
            state <= sWaitAckLow;
          end
        end
        sWaitAckLow: begin
          if (!memAck) begin
            if (opReg == memBusPkg::MEM_WRITE) begin
              state <= sIdle;
            end else if (lastWord) begin
              state <= sInstall;
            end else begin
              state <= sRequest;         // next word of the block
            end
          end
        end
        sInstall: state <= sIdle;        // busy falls with the tag written
        default:  state <= sIdle;
      endcase
    end
  end

  // address and data capture
  always_ff @(posedge clk) begin
    case (state)
      sIdle: begin
        if (wrThrough) begin
          addrReg  <= addrCpu;
          wDataReg <= dataInCpu;
        end else if (miss) begin
          addrReg.raw <= {addrCpu.fields.tag, addrCpu.fields.set,
                          {`CACHE_OFS_W{1'b0}}, 1'b0};  // start at word 0
        end
      end
      sRequest: begin
        if (memAck) begin
          fillData <= memRData;          // sample while ack is high
        end
      end
      sWaitAckLow: begin
        if (!memAck && (opReg == memBusPkg::MEM_READ) && !lastWord) begin
          addrReg.fields.offset <= addrReg.fields.offset +
                                   {{(`CACHE_OFS_W-1){1'b0}}, 1'b1};
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== testbench/mainMemoryModel.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "cache_params.svh"

module mainMemoryModel (
  input  wire                      clk,
  input  wire                      rstN,
  input  wire                      memReq,
  input  wire  memBusPkg::memOpT   memOp,
  input  wire  [15:0]              memAddr,
  input  wire  [`CACHE_DATA_W-1:0] memWData,
  input  wire  [1:0]               delayMax,     // longest ack delay in cycles
  input  wire                      delayRandom,  // 0 means every ack waits delayMax
  output logic                     memAck,
  output logic [`CACHE_DATA_W-1:0] memRData
);

  logic [`CACHE_DATA_W-1:0] shadow [32768];  // one entry per 16 bit word
  integer seed;
  logic waiting;                              // request seen, delay running
  logic [1:0] delayLeft;

  // delay for the request that just arrived
  function automatic logic [1:0] nextDelay();
    int r;
    r = $random(seed);
    return delayRandom ? 2'($unsigned(r) % (delayMax + 1)) : delayMax;
  endfunction

  initial begin
    seed = 73;
    for (int i = 0; i < 32768; i++) begin
      shadow[i] = 16'($random(seed));  // random power up contents
    end
  end

  //////////////////////////////////////////////////
  // four phase responder
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstN) begin
      memAck    <= 1'b0;
      memRData  <= '0;
      waiting   <= 1'b0;
      delayLeft <= 2'd0;
    end else if (memAck) begin
      if (!memReq) begin
        memAck <= 1'b0;                 // req seen low, handshake over
      end
    end else if (memReq && !waiting) begin
      waiting   <= 1'b1;                // new request, pick its delay
      delayLeft <= nextDelay();
    end else if (waiting) begin
      if (delayLeft != 2'd0) begin
        delayLeft <= delayLeft - 2'd1;
      end else begin
        if (memOp == memBusPkg::MEM_WRITE) begin
          shadow[memAddr[15:1]] = memWData;  // byte bit ignored
        end
        memRData <= shadow[memAddr[15:1]];
        memAck   <= 1'b1;
        waiting  <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tbCacheTop.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "cache_params.svh"

module tbCacheTop;

  localparam int ClkPeriod   = 4;   // ns
  localparam int TestCount   = 10;  // five tests, two ack delay modes
  localparam int RefillsMax  = 4;   // per test, the lru test is the worst
  localparam int HsMaxCycles = 8;   // one handshake at the longest ack delay
  localparam int WatchdogNs  = TestCount * RefillsMax * `CACHE_WORDS * HsMaxCycles
                               * ClkPeriod + 2000;
  localparam int AccessLimit = 200;  // cycles one access may stall

  logic clk, rstN, rd, wr, stall, memReq, memAck, delayRandom;
  logic [15:0] addrCpu, memAddr;
  logic [`CACHE_DATA_W-1:0] dataInCpu, dataOutCpu, memWData, memRData;
  logic [1:0] delayMax;
  memBusPkg::memOpT memOp;

  logic [15:0] rdAddrQ [$];            // addresses of finished read handshakes
  int wrCount;                         // finished write handshakes
  memBusPkg::memOpT lastOp;
  logic [15:0] lastAddr;
  logic [`CACHE_DATA_W-1:0] lastWData;

  cacheTop u_dut (
    .clk(clk), .rstN(rstN), .rd(rd), .wr(wr), .addrCpu(addrCpu), .dataInCpu(dataInCpu),
    .memAck(memAck), .memRData(memRData), .dataOutCpu(dataOutCpu), .stall(stall),
    .memReq(memReq), .memOp(memOp), .memAddr(memAddr), .memWData(memWData)
  );

  mainMemoryModel u_mem (
    .clk(clk), .rstN(rstN), .memReq(memReq), .memOp(memOp), .memAddr(memAddr),
    .memWData(memWData), .delayMax(delayMax), .delayRandom(delayRandom),
    .memAck(memAck), .memRData(memRData)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // one count per handshake, at the edge where the cache takes the ack
  always @(posedge clk) begin
    if (memReq && memAck) begin
      lastOp    = memOp;
      lastAddr  = memAddr;
      lastWData = memWData;
      if (memOp == memBusPkg::MEM_READ) begin
        rdAddrQ.push_back(memAddr);
      end else begin
        wrCount = wrCount + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // helpers and compares
  //////////////////////////////////////////////////

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic cmpData(input string name, input logic [`CACHE_DATA_W-1:0] exp, act);
    if (act !== exp) stopRun($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic cmpAddr(input string name, input cacheTypesPkg::cacheAddrT exp, act);
    if (act.raw !== exp.raw) begin
      stopRun($sformatf("ERR %s expected %h actual %h", name, exp.raw, act.raw));
    end
  endtask

  task automatic cmpOp(input string name, input memBusPkg::memOpT exp, act);
    if (act !== exp) stopRun($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic cmpCount(input string name, input int exp, act);
    if (act != exp) stopRun($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  function automatic cacheTypesPkg::cacheAddrT mkAddr(input int tag, set, ofs);
    cacheTypesPkg::cacheAddrT a;
    a.raw          = '0;  // byte select stays 0
    a.fields.tag    = tag[`CACHE_TAG_W-1:0];
    a.fields.set    = set[`CACHE_SET_W-1:0];
    a.fields.offset = ofs[`CACHE_OFS_W-1:0];
    return a;
  endfunction

  function automatic logic [`CACHE_DATA_W-1:0] shadowWord(input cacheTypesPkg::cacheAddrT a);
    return u_mem.shadow[a.raw[15:1]];  // what memory holds right now
  endfunction

  task automatic clearCounts();
    rdAddrQ.delete();
    wrCount = 0;
  endtask

  task automatic applyReset();
    @(posedge clk);
    rstN <= 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
  endtask

  // hold rd or wr until stall is low, the access completes at the next edge
  task automatic cpuAccess(input logic isWrite, input cacheTypesPkg::cacheAddrT addr,
                           input logic [`CACHE_DATA_W-1:0] wData,
                           output logic [`CACHE_DATA_W-1:0] rData);
    int cycles;
    cycles = 0;
    @(posedge clk);
    rd        <= !isWrite;
    wr        <= isWrite;
    addrCpu   <= addr.raw;
    dataInCpu <= wData;
    @(negedge clk);
    while (stall) begin
      cycles++;
      if (cycles > AccessLimit) stopRun("a cpu access stayed stalled past the cycle limit");
      @(negedge clk);
    end
    rData = dataOutCpu;  // stable mid cycle
    @(posedge clk);
    rd <= 1'b0;
    wr <= 1'b0;
  endtask

  // wait out a trailing write through or metadata update
  task automatic waitIdle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (stall) begin
      cycles++;
      if (cycles > AccessLimit) stopRun("the cache stayed busy past the cycle limit");
      @(negedge clk);
    end
  endtask

  task automatic checkRead(input cacheTypesPkg::cacheAddrT addr);
    logic [`CACHE_DATA_W-1:0] rData;
    cpuAccess(1'b0, addr, '0, rData);
    cmpData("dataOutCpu", shadowWord(addr), rData);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic testMissRefill(input cacheTypesPkg::cacheAddrT addr);
    cacheTypesPkg::cacheAddrT blk;
    int i;
    clearCounts();
    checkRead(addr);
    cmpCount("memReadCount", `CACHE_WORDS, rdAddrQ.size());
    for (i = 0; i < `CACHE_WORDS; i++) begin
      blk = mkAddr(addr.fields.tag, addr.fields.set, i);  // words 0 to 7 in order
      cmpAddr("memAddr", blk, rdAddrQ[i]);
    end
    cmpCount("memWriteCount", 0, wrCount);
  endtask

  task automatic testHitSameBlock(input cacheTypesPkg::cacheAddrT addr);
    int i;
    clearCounts();
    for (i = 0; i < `CACHE_WORDS; i++) begin
      checkRead(mkAddr(addr.fields.tag, addr.fields.set, i));
    end
    cmpCount("memReadCount", 0, rdAddrQ.size());
    cmpCount("memWriteCount", 0, wrCount);
  endtask

  task automatic testWriteHit(input cacheTypesPkg::cacheAddrT addr,
                              input logic [`CACHE_DATA_W-1:0] data);
    logic [`CACHE_DATA_W-1:0] rData;
    clearCounts();
    cpuAccess(1'b1, addr, data, rData);
    waitIdle();
    cmpCount("memWriteCount", 1, wrCount);
    cmpCount("memReadCount", 0, rdAddrQ.size());
    cmpOp("memOp", memBusPkg::MEM_WRITE, lastOp);
    cmpAddr("memAddr", addr, lastAddr);
    cmpData("memWData", data, lastWData);
    cmpData("shadow", data, shadowWord(addr));
    cpuAccess(1'b0, addr, '0, rData);
    cmpData("dataOutCpu", data, rData);
    cmpCount("memReadCount", 0, rdAddrQ.size());
  endtask

  // tags 1, 2, 3 share one set, 3 must push out 2
  task automatic testLruReplace(input int set);
    checkRead(mkAddr(1, set, 1));
    checkRead(mkAddr(2, set, 2));
    checkRead(mkAddr(1, set, 3));  // tag 1 becomes most recent
    checkRead(mkAddr(3, set, 4));
    clearCounts();
    checkRead(mkAddr(1, set, 5));
    cmpCount("memReadCount", 0, rdAddrQ.size());
    checkRead(mkAddr(2, set, 6));
    cmpCount("memReadCount", `CACHE_WORDS, rdAddrQ.size());
  endtask

  task automatic testWriteMiss(input cacheTypesPkg::cacheAddrT addr,
                               input logic [`CACHE_DATA_W-1:0] data);
    logic [`CACHE_DATA_W-1:0] rData;
    clearCounts();
    cpuAccess(1'b1, addr, data, rData);
    waitIdle();
    cmpCount("memReadCount", `CACHE_WORDS, rdAddrQ.size());
    cmpCount("memWriteCount", 1, wrCount);
    cmpOp("memOp", memBusPkg::MEM_WRITE, lastOp);  // write through comes after the fill
    cmpAddr("memAddr", addr, lastAddr);
    cmpData("memWData", data, lastWData);
    cmpData("shadow", data, shadowWord(addr));
    clearCounts();
    cpuAccess(1'b0, addr, '0, rData);
    cmpData("dataOutCpu", data, rData);
    cmpCount("memReadCount", 0, rdAddrQ.size());
    cmpCount("memWriteCount", 0, wrCount);
  endtask

  task automatic runAll(input logic [`CACHE_DATA_W-1:0] salt);
    testMissRefill(mkAddr(5, 3, 2));
    testHitSameBlock(mkAddr(5, 3, 0));
    testWriteHit(mkAddr(5, 3, 4), 16'h5A3C ^ salt);
    testLruReplace(9);
    testWriteMiss(mkAddr(7, 20, 5), 16'hC0DE ^ salt);
  endtask

  initial begin
    rstN        = 1'b0;
    rd          = 1'b0;
    wr          = 1'b0;
    addrCpu     = '0;
    dataInCpu   = '0;
    delayMax    = 2'd3;
    delayRandom = 1'b1;  // first pass, random ack delay 0 to 3
    clearCounts();
    applyReset();
    runAll(16'h0000);
    @(posedge clk);
    delayRandom <= 1'b0;  // second pass, every ack at the longest delay
    applyReset();
    runAll(16'hFFFF);
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire
